/* hw/m6502_pkg.sv */
// Widths, enums and structs shared by the modules of the 6502-style core
// Compile this package ahead of the RTL files
package m6502_pkg;

  typedef logic [7:0] byte_t;
  typedef logic [15:0] addr_t;

  // Only N, Z and C are kept
  typedef struct packed {
    logic neg;
    logic zero;
    logic carry;
  } flags_t;

  typedef enum logic [2:0] {
    ALU_ORA,
    ALU_AND,
    ALU_EOR,
    ALU_ADC,
    ALU_LDA,
    ALU_CMP,
    ALU_SBC,
    ALU_PASS
  } alu_op_t;

  typedef enum logic [2:0] {
    AM_IMPLIED,
    AM_IMMEDIATE,
    AM_ZP,
    AM_ZP_X,
    AM_ABS,
    AM_ABS_X,
    AM_ABS_Y,
    AM_RELATIVE
  } addr_mode_t;

  typedef enum logic [1:0] {
    REG_A,
    REG_X,
    REG_Y,
    REG_NONE
  } reg_sel_t;

  typedef struct packed {
    addr_mode_t mode;
    alu_op_t    alu_op;
    reg_sel_t   src;
    reg_sel_t   dst;
    logic       is_store;
    logic       is_branch;
    logic       is_jump;
    logic       is_brk;
    logic       illegal;
    logic [1:0] branch_flag;
    logic       branch_value;
    logic       carry_set;
    logic       carry_clear;
  } decoded_t;

  // Write-back request from the control to the register block
  typedef struct packed {
    logic     en;
    reg_sel_t dst;
    byte_t    data;
    logic     flags_en;
    flags_t   flags;
  } reg_wr_t;

  typedef struct packed {
    addr_t addr;
    byte_t wdata;
    logic  we;
  } mem_req_t;

endpackage

/* hw/cpu_decode.sv */
// Opcode decoder, purely combinational
// Maps the kept subset onto decoded_t and flags everything else illegal
`timescale 1ns/1ps

module cpu_decode
(
  input  m6502_pkg::byte_t    opcode,
  output m6502_pkg::decoded_t dec
);
  import m6502_pkg::*;

  // Opcode layout aaabbbcc
  logic [2:0] op_field;
  logic [2:0] mode_field;
  logic [1:0] col_field;
  reg_sel_t   index_reg;

  assign op_field = opcode[7:5];
  assign mode_field = opcode[4:2];
  assign col_field = opcode[1:0];
  assign index_reg = col_field[1] ? REG_X : REG_Y;

  function automatic decoded_t reg_op(reg_sel_t src, reg_sel_t dst);
    decoded_t d;
    d = '0;
    d.mode = AM_IMPLIED;
    d.alu_op = ALU_PASS;
    d.src = src;
    d.dst = dst;
    return d;
  endfunction

  always_comb
  begin
    dec = reg_op(REG_NONE, REG_NONE);
    dec.illegal = 1'b1;
    case (col_field)
      2'b01:
      begin
        // No indirect modes, no STA immediate
        dec.illegal = (mode_field == 3'b000) || (mode_field == 3'b100) ||
                      (opcode == 8'h89);
        case (mode_field)
          3'b001: dec.mode = AM_ZP;
          3'b010: dec.mode = AM_IMMEDIATE;
          3'b011: dec.mode = AM_ABS;
          3'b101: dec.mode = AM_ZP_X;
          3'b110: dec.mode = AM_ABS_Y;
          default: dec.mode = AM_ABS_X;
        endcase
        case (op_field)
          3'b000: dec.alu_op = ALU_ORA;
          3'b001: dec.alu_op = ALU_AND;
          3'b010: dec.alu_op = ALU_EOR;
          3'b011: dec.alu_op = ALU_ADC;
          3'b101: dec.alu_op = ALU_LDA;
          3'b110: dec.alu_op = ALU_CMP;
          3'b111: dec.alu_op = ALU_SBC;
          default: dec.alu_op = ALU_PASS;
        endcase
        dec.is_store = (op_field == 3'b100);
        dec.src = REG_A;
        dec.dst = (op_field == 3'b100 || op_field == 3'b110) ? REG_NONE : REG_A;
      end
      2'b00, 2'b10:
      begin
        // LDX LDY STX STY
        if ((op_field == 3'b100 || op_field == 3'b101) &&
            (mode_field == 3'b001 || mode_field == 3'b011 ||
             (mode_field == 3'b000 && op_field[0])))
        begin
          dec.illegal = 1'b0;
          if (mode_field == 3'b000)
            dec.mode = AM_IMMEDIATE;
          else if (mode_field == 3'b001)
            dec.mode = AM_ZP;
          else
            dec.mode = AM_ABS;
          dec.is_store = !op_field[0];
          dec.src = index_reg;
          dec.dst = op_field[0] ? index_reg : REG_NONE;
        end
      end
      default: ;
    endcase

    case (opcode)
      8'h00:
      begin
        dec = reg_op(REG_NONE, REG_NONE);
        dec.is_brk = 1'b1;
      end
      8'h4c:
      begin
        dec = reg_op(REG_NONE, REG_NONE);
        dec.mode = AM_ABS;
        dec.is_jump = 1'b1;
      end
      8'h18:
      begin
        dec = reg_op(REG_NONE, REG_NONE);
        dec.carry_clear = 1'b1;
      end
      8'h38:
      begin
        dec = reg_op(REG_NONE, REG_NONE);
        dec.carry_set = 1'b1;
      end
      8'haa: dec = reg_op(REG_A, REG_X);
      8'ha8: dec = reg_op(REG_A, REG_Y);
      8'h8a: dec = reg_op(REG_X, REG_A);
      8'h98: dec = reg_op(REG_Y, REG_A);
      8'he8, 8'hca: dec = reg_op(REG_X, REG_X);
      8'hc8, 8'h88: dec = reg_op(REG_Y, REG_Y);
      8'h10, 8'h30, 8'h90, 8'hb0, 8'hd0, 8'hf0:
      begin
        dec = reg_op(REG_NONE, REG_NONE);
        dec.mode = AM_RELATIVE;
        dec.is_branch = 1'b1;
        dec.branch_flag = opcode[7:6];
        dec.branch_value = opcode[5];
      end
      default: ;
    endcase
  end

endmodule

/* hw/cpu_alu.sv */
// Accumulator-group ALU, combinational
// Result byte and new N/Z/C for the write-back
`timescale 1ns/1ps

module cpu_alu
(
  input  m6502_pkg::alu_op_t op,
  input  m6502_pkg::byte_t   reg_a,
  input  m6502_pkg::byte_t   operand,
  input  m6502_pkg::flags_t  flags_in,
  output m6502_pkg::byte_t   result,
  output m6502_pkg::flags_t  flags_out
);
  import m6502_pkg::*;

  logic [8:0] sum;
  logic [8:0] diff;
  logic       borrow_in_n;
  logic       carry;

  // CMP subtracts as if carry were set
  assign borrow_in_n = (op == ALU_CMP) || flags_in.carry;

  assign sum = {1'b0, reg_a} + {1'b0, operand} + {8'd0, flags_in.carry};
  assign diff = {1'b0, reg_a} + {1'b0, ~operand} + {8'd0, borrow_in_n};

  always_comb
  begin
    result = operand;
    carry = flags_in.carry;
    case (op)
      ALU_ORA: result = reg_a | operand;
      ALU_AND: result = reg_a & operand;
      ALU_EOR: result = reg_a ^ operand;
      ALU_ADC:
      begin
        result = sum[7:0];
        carry = sum[8];
      end
      ALU_CMP, ALU_SBC:
      begin
        // Carry out means no borrow
        result = diff[7:0];
        carry = diff[8];
      end
      default: result = operand;
    endcase
  end

  assign flags_out.neg = result[7];
  assign flags_out.zero = (result == 8'h00);
  assign flags_out.carry = carry;

endmodule

/* hw/cpu_regs.sv */
// A, X, Y and the N/Z/C flags
// Written by write-back requests from the control sequencer
`timescale 1ns/1ps

module cpu_regs
(
  input  logic               raw_clk,
  input  logic               button_reset,
  input  m6502_pkg::reg_wr_t reg_wr,
  output m6502_pkg::byte_t   reg_a,
  output m6502_pkg::byte_t   reg_x,
  output m6502_pkg::byte_t   reg_y,
  output m6502_pkg::flags_t  flags
);
  import m6502_pkg::*;

  always_ff @(posedge raw_clk)
  begin
    if (!button_reset)
    begin
      reg_a <= '0;
      reg_x <= '0;
      reg_y <= '0;
      flags <= '0;
    end
    else
    begin
      if (reg_wr.en)
      begin
        case (reg_wr.dst)
          REG_A: reg_a <= reg_wr.data;
          REG_X: reg_x <= reg_wr.data;
          REG_Y: reg_y <= reg_wr.data;
          default: ;
        endcase
      end
      // Flags may change without a register write, e.g. CMP
      if (reg_wr.flags_en)
        flags <= reg_wr.flags;
    end
  end

  // Control only requests writes to a real register
  assert property (@(posedge raw_clk) disable iff (!button_reset)
    reg_wr.en |-> (reg_wr.dst != REG_NONE));

endmodule

/* hw/cpu_control.sv */
// Fetch, address and execute sequencer of the core
// Owns pc and the memory port, and issues register write-backs
`timescale 1ns/1ps

module cpu_control
#(
  parameter m6502_pkg::addr_t RESET_VECTOR = 16'h4000
)
(
  input  logic                 raw_clk,
  input  logic                 button_reset,
  input  logic                 button_halt,
  input  m6502_pkg::byte_t     mem_rdata,
  output m6502_pkg::mem_req_t  mem_req,
  output logic                 sync,
  output logic                 halted,
  output logic                 error,
  output m6502_pkg::byte_t     opcode,
  input  m6502_pkg::decoded_t  dec,
  input  m6502_pkg::byte_t     reg_a,
  input  m6502_pkg::byte_t     reg_x,
  input  m6502_pkg::byte_t     reg_y,
  input  m6502_pkg::flags_t    flags,
  input  m6502_pkg::byte_t     alu_result,
  input  m6502_pkg::flags_t    alu_flags,
  output m6502_pkg::reg_wr_t   reg_wr
);
  import m6502_pkg::*;

  typedef enum logic [3:0] {
    FETCH_OP,
    DECODE,
    FETCH_LO,
    FETCH_HI,
    READ_MEM,
    EXECUTE,
    STORE,
    HALT_WAIT,
    HALTED,
    ERROR
  } state_t;

  state_t state;
  state_t fetch_next;
  state_t mem_next;
  logic   second;
  logic   two_phase;
  logic   use_ea;
  addr_t  pc;
  addr_t  ea;
  addr_t  zp_addr;
  addr_t  abs_addr;
  byte_t  ir;
  byte_t  operand_q;
  byte_t  src_val;
  byte_t  step_val;
  byte_t  index_val;
  logic   step_down;
  logic   branch_taken;

  // Memory cycles take an address phase and a capture phase
  assign two_phase = (state == FETCH_OP) || (state == FETCH_LO) ||
                     (state == FETCH_HI) || (state == READ_MEM);
  assign use_ea = (state == READ_MEM) || (state == STORE);

  assign mem_req.addr = use_ea ? ea : pc;
  assign mem_req.wdata = operand_q;
  assign mem_req.we = (state == STORE);
  assign sync = (state == FETCH_OP) && !second;
  assign halted = (state == HALTED);
  assign error = (state == ERROR);
  assign opcode = ir;

  assign fetch_next = button_halt ? FETCH_OP : HALT_WAIT;
  assign mem_next = dec.is_store ? STORE : READ_MEM;

  always_comb
  begin
    case (dec.src)
      REG_A: src_val = reg_a;
      REG_X: src_val = reg_x;
      REG_Y: src_val = reg_y;
      default: src_val = 8'h00;
    endcase
  end

  // Only DEX and DEY count down
  assign step_down = (ir == 8'h88) || (ir == 8'hca);

  always_comb
  begin
    step_val = src_val;
    if (dec.mode == AM_IMPLIED && dec.src == dec.dst)
      step_val = step_down ? src_val - 8'd1 : src_val + 8'd1;
  end

  always_comb
  begin
    case (dec.mode)
      AM_ZP_X, AM_ABS_X: index_val = reg_x;
      AM_ABS_Y: index_val = reg_y;
      default: index_val = 8'h00;
    endcase
  end

  // Zero page sum stays 8 bits wide so ZP,X wraps
  assign zp_addr = {8'h00, mem_rdata + index_val};
  assign abs_addr = {mem_rdata, operand_q} + {8'h00, index_val};

  // Flag select is opcode bits 7:6
  always_comb
  begin
    case (dec.branch_flag)
      2'b00: branch_taken = (flags.neg == dec.branch_value);
      2'b10: branch_taken = (flags.carry == dec.branch_value);
      default: branch_taken = (flags.zero == dec.branch_value);
    endcase
  end

  always_comb
  begin
    reg_wr.en = (state == EXECUTE) && (dec.dst != REG_NONE);
    reg_wr.dst = dec.dst;
    reg_wr.data = alu_result;
    reg_wr.flags_en = (state == EXECUTE) && !dec.is_branch;
    reg_wr.flags = alu_flags;
    if (dec.carry_set || dec.carry_clear)
    begin
      reg_wr.flags = flags;
      reg_wr.flags.carry = dec.carry_set;
    end
  end

  always_ff @(posedge raw_clk)
  begin
    if (!button_reset)
    begin
      state <= HALT_WAIT;
      second <= 1'b0;
      pc <= RESET_VECTOR;
    end
    else
    begin
      second <= two_phase && !second;
      case (state)
        HALT_WAIT:
          if (button_halt)
            state <= FETCH_OP;
        FETCH_OP:
          if (second)
          begin
            ir <= mem_rdata;
            pc <= pc + 16'd1;
            state <= DECODE;
          end
        DECODE:
        begin
          // Implied ops take their operand from a register
          operand_q <= step_val;
          if (dec.illegal)
            state <= ERROR;
          else if (dec.is_brk)
            state <= HALTED;
          else if (dec.mode == AM_IMPLIED)
            state <= EXECUTE;
          else
            state <= FETCH_LO;
        end
        FETCH_LO:
          if (second)
          begin
            pc <= pc + 16'd1;
            operand_q <= mem_rdata;
            ea <= zp_addr;
            case (dec.mode)
              AM_IMMEDIATE, AM_RELATIVE:
                state <= EXECUTE;
              AM_ZP, AM_ZP_X:
              begin
                state <= mem_next;
                if (dec.is_store)
                  operand_q <= src_val;
              end
              default:
                state <= FETCH_HI;
            endcase
          end
        FETCH_HI:
          if (second)
          begin
            ea <= abs_addr;
            operand_q <= src_val;
            if (dec.is_jump)
            begin
              pc <= {mem_rdata, operand_q};
              state <= fetch_next;
            end
            else
            begin
              pc <= pc + 16'd1;
              state <= mem_next;
            end
          end
        READ_MEM:
          if (second)
          begin
            operand_q <= mem_rdata;
            state <= EXECUTE;
          end
        EXECUTE:
        begin
          if (dec.is_branch && branch_taken)
            pc <= pc + {{8{operand_q[7]}}, operand_q};
          state <= fetch_next;
        end
        STORE:
          state <= fetch_next;
        HALTED, ERROR: ;
        default:
          state <= ERROR;
      endcase
    end
  end

  // A store never lands on an opcode fetch
  assert property (@(posedge raw_clk) disable iff (!button_reset)
    !(mem_req.we && sync));

  assert property (@(posedge raw_clk) disable iff (!button_reset)
    !(halted && error));

endmodule

/* hw/m6502_top.sv */
// Top level of the 6502-style core
// Memory sits outside on a synchronous byte-wide port
`timescale 1ns/1ps

module m6502_top
#(
  parameter m6502_pkg::addr_t RESET_VECTOR = 16'h4000
)
(
  input  logic                raw_clk,
  input  logic                button_reset,
  input  logic                button_halt,
  output m6502_pkg::mem_req_t mem_req,
  input  m6502_pkg::byte_t    mem_rdata,
  output logic                sync,
  output logic                halted,
  output logic                error
);
  import m6502_pkg::*;

  byte_t    opcode;
  decoded_t dec;
  byte_t    reg_a;
  byte_t    reg_x;
  byte_t    reg_y;
  flags_t   flags;
  byte_t    alu_result;
  flags_t   alu_flags;
  reg_wr_t  reg_wr;

  cpu_control #(
    .RESET_VECTOR (RESET_VECTOR)
  ) cpu_control_inst (
    .raw_clk      (raw_clk),
    .button_reset (button_reset),
    .button_halt  (button_halt),
    .mem_rdata    (mem_rdata),
    .mem_req      (mem_req),
    .sync         (sync),
    .halted       (halted),
    .error        (error),
    .opcode       (opcode),
    .dec          (dec),
    .reg_a        (reg_a),
    .reg_x        (reg_x),
    .reg_y        (reg_y),
    .flags        (flags),
    .alu_result   (alu_result),
    .alu_flags    (alu_flags),
    .reg_wr       (reg_wr)
  );

  cpu_decode cpu_decode_inst (
    .opcode (opcode),
    .dec    (dec)
  );

  cpu_regs cpu_regs_inst (
    .raw_clk      (raw_clk),
    .button_reset (button_reset),
    .reg_wr       (reg_wr),
    .reg_a        (reg_a),
    .reg_x        (reg_x),
    .reg_y        (reg_y),
    .flags        (flags)
  );

  // The write-data register doubles as the operand latch
  cpu_alu cpu_alu_inst (
    .op        (dec.alu_op),
    .reg_a     (reg_a),
    .operand   (mem_req.wdata),
    .flags_in  (flags),
    .result    (alu_result),
    .flags_out (alu_flags)
  );

endmodule

/* testbench/tb_cases.svh */
// Test programs for the core testbench, included inside tb_m6502
// Each program sits at the reset vector, padded with BRK, and lists its writes
task automatic build_cases();
  byte_t      r0;
  byte_t      r1;
  byte_t      r2;
  byte_t      r3;
  byte_t      v1;
  byte_t      v2;
  logic [8:0] sum;
  r0 = byte_t'($urandom);
  r1 = byte_t'($urandom);
  r2 = byte_t'($urandom);
  r3 = byte_t'($urandom);

  new_case("load_store", {8'ha9, r0, 8'h85, 8'h30, 8'ha2, r1, 8'h8e, 8'h31, 8'h02,
           8'ha0, r2, 8'h84, 8'h32, {3{8'h00}}}, 1'b0, 0);
  expect_write(16'h0030, r0);
  expect_write(16'h0231, r1);
  expect_write(16'h0032, r2);

  new_case("logic_ops", {8'ha9, r0, 8'h09, r1, 8'h85, 8'h40, 8'h29, r2, 8'h85, 8'h41,
           8'h49, r3, 8'h85, 8'h42, {2{8'h00}}}, 1'b0, 0);
  v1 = r0 | r1;
  v2 = v1 & r2;
  expect_write(16'h0040, v1);
  expect_write(16'h0041, v2);
  expect_write(16'h0042, v2 ^ r3);

  // CLC before ADC, SEC before SBC, so no borrow in
  new_case("adc_sbc_imm", {8'h18, 8'ha9, r0, 8'h69, r1, 8'h85, 8'h50, 8'h38, 8'he9, r2,
           8'h85, 8'h51, {4{8'h00}}}, 1'b0, 0);
  sum = {1'b0, r0} + {1'b0, r1};
  v1 = sum[7:0];
  expect_write(16'h0050, v1);
  expect_write(16'h0051, v1 - r2);

  // SBC takes the carry left by ADC
  new_case("adc_sbc_zp", {8'ha9, r0, 8'h85, 8'h60, 8'ha9, r1, 8'h38, 8'h65, 8'h60, 8'h85,
           8'h61, 8'he5, 8'h60, 8'h85, 8'h62, 8'h00}, 1'b0, 0);
  sum = {1'b0, r1} + {1'b0, r0} + 9'd1;
  v1 = sum[7:0];
  v2 = v1 - r0 - {7'd0, ~sum[8]};
  expect_write(16'h0060, r0);
  expect_write(16'h0061, v1);
  expect_write(16'h0062, v2);

  new_case("zp_x_wrap", {8'ha2, 8'hf8, 8'ha9, r0, 8'h95, 8'h10, 8'he8, 8'h86, 8'h20,
           8'ha9, r1, 8'haa, 8'h86, 8'h21, {2{8'h00}}}, 1'b0, 0);
  expect_write(16'h0008, r0);
  expect_write(16'h0020, 8'hf9);
  expect_write(16'h0021, r1);

  // Second store crosses into the next page
  new_case("abs_y_index", {8'ha0, 8'h03, 8'h88, 8'h98, 8'h99, 8'h00, 8'h03, 8'ha0, 8'hf0,
           8'h99, 8'hf0, 8'h03, {4{8'h00}}}, 1'b0, 0);
  expect_write(16'h0302, 8'h02);
  expect_write(16'h04e0, 8'h02);

  new_case("cmp_beq", {8'ha9, r0, 8'hc9, r0, 8'hf0, 8'h02, 8'h85, 8'h70, 8'hc9, r0 ^ 8'h01,
           8'hf0, 8'h02, 8'h85, 8'h72, {2{8'h00}}}, 1'b0, 0);
  expect_write(16'h0072, r0);

  new_case("bne_loop", {8'ha2, 8'h04, 8'h8a, 8'h95, 8'h80, 8'hca, 8'hd0, 8'hfa,
           {8{8'h00}}}, 1'b0, 0);
  expect_write(16'h0084, 8'h04);
  expect_write(16'h0083, 8'h03);
  expect_write(16'h0082, 8'h02);
  expect_write(16'h0081, 8'h01);

  // Both operands high, carry out
  v1 = r0 | 8'h80;
  v2 = r1 | 8'h80;
  new_case("bcs_after_adc", {8'h18, 8'ha9, v1, 8'h69, v2, 8'hb0, 8'h02, 8'h85, 8'h90,
           8'h90, 8'h02, 8'h85, 8'h91, {3{8'h00}}}, 1'b0, 0);
  expect_write(16'h0091, v1 + v2);

  v1 = r0 & 8'h7f;
  v2 = r1 & 8'h7f;
  new_case("bcc_after_adc", {8'h18, 8'ha9, v1, 8'h69, v2, 8'hb0, 8'h02, 8'h85, 8'h90,
           8'h90, 8'h02, 8'h85, 8'h91, {3{8'h00}}}, 1'b0, 0);
  expect_write(16'h0090, v1 + v2);

  new_case("jmp_brk", {8'ha9, r0, 8'h4c, 8'h07, 8'h40, 8'h85, 8'ha0, 8'h85, 8'ha1, 8'h00,
           8'h85, 8'ha2, {4{8'h00}}}, 1'b0, 0);
  expect_write(16'h00a1, r0);

  new_case("illegal_opcode", {8'ha9, r0, 8'h85, 8'hb0, 8'hff, 8'h85, 8'hb1,
           {9{8'h00}}}, 1'b1, 0);
  expect_write(16'h00b0, r0);

  // Loop again, held after the third opcode fetch
  new_case("halt_button", {8'ha2, 8'h04, 8'h8a, 8'h95, 8'h80, 8'hca, 8'hd0, 8'hfa,
           {8{8'h00}}}, 1'b0, 3);
  expect_write(16'h0084, 8'h04);
  expect_write(16'h0083, 8'h03);
  expect_write(16'h0082, 8'h02);
  expect_write(16'h0081, 8'h01);
endtask

/* testbench/tb_m6502.sv */
// Testbench for the 6502-style core
// Runs each program of the case table against a synchronous memory model
`timescale 1ns/1ps

module tb_m6502;
  import m6502_pkg::*;

  localparam int MAX_CASES = 16;
  localparam int MAX_WRITES = 8;
  localparam int MAX_WAIT = 2000;
  localparam int HOLD_CYCLES = 50;
  localparam int HOLD_SETTLE = 12;
  localparam int STOP_WATCH = 20;
  localparam addr_t PROG_BASE = 16'h4000;

  logic     raw_clk = 1'b0;
  logic     button_reset = 1'b0;
  logic     button_halt = 1'b1;
  byte_t    mem_rdata = 8'h00;
  mem_req_t mem_req;
  logic     sync;
  logic     halted;
  logic     error;

  byte_t    mem [0:65535];
  addr_t    rd_addr = 16'h0000;
  addr_t    log_addr [$];
  byte_t    log_data [$];

  // Case table, filled by build_cases
  string    case_name [MAX_CASES];
  byte_t    case_prog [MAX_CASES][16];
  logic     case_illegal [MAX_CASES];
  int       case_hold [MAX_CASES];
  int       case_writes [MAX_CASES];
  addr_t    exp_addr [MAX_CASES][MAX_WRITES];
  byte_t    exp_data [MAX_CASES][MAX_WRITES];
  int       num_cases = 0;

  int       test_errors = 0;
  int       pass_count = 0;
  int       fail_count = 0;

  m6502_top m6502_top_inst (
    .raw_clk      (raw_clk),
    .button_reset (button_reset),
    .button_halt  (button_halt),
    .mem_req      (mem_req),
    .mem_rdata    (mem_rdata),
    .sync         (sync),
    .halted       (halted),
    .error        (error)
  );

  initial
  begin
    forever
    begin
      #20 raw_clk = ~raw_clk;
    end
  end

  // Request is sampled mid-cycle
  always @(negedge raw_clk)
  begin
    rd_addr = mem_req.addr;
    if (button_reset && mem_req.we)
    begin
      mem[mem_req.addr] = mem_req.wdata;
      log_addr.push_back(mem_req.addr);
      log_data.push_back(mem_req.wdata);
    end
  end

  // Read data one cycle after the address
  always @(posedge raw_clk)
  begin
    #1;
    mem_rdata = mem[rd_addr];
  end

  function automatic byte_t fill_byte(addr_t a);
    return a[15:8] ^ {a[6:0], a[7]} ^ 8'h3c;
  endfunction

  // Program bytes are packed first byte in the top bits
  task automatic new_case(string name, logic [127:0] code, logic illegal, int hold);
    int i;
    case_name[num_cases] = name;
    for (i = 0; i < 16; i++)
      case_prog[num_cases][i] = code[127 - 8 * i -: 8];
    case_illegal[num_cases] = illegal;
    case_hold[num_cases] = hold;
    case_writes[num_cases] = 0;
    num_cases++;
  endtask

  task automatic expect_write(addr_t addr, byte_t data);
    exp_addr[num_cases - 1][case_writes[num_cases - 1]] = addr;
    exp_data[num_cases - 1][case_writes[num_cases - 1]] = data;
    case_writes[num_cases - 1]++;
  endtask

  `include "tb_cases.svh"

  task automatic check_addr(string name, addr_t got, addr_t expected);
    if (got !== expected)
    begin
      $display("** Error: %s got 0x%04h expected 0x%04h", name, got, expected);
      test_errors++;
    end
  endtask

  task automatic check_byte(string name, byte_t got, byte_t expected);
    if (got !== expected)
    begin
      $display("** Error: %s got 0x%02h expected 0x%02h", name, got, expected);
      test_errors++;
    end
  endtask

  task automatic load_memory(int idx);
    int a;
    for (a = 0; a < 65536; a++)
      mem[a] = fill_byte(addr_t'(a));
    for (a = 0; a < 16; a++)
      mem[PROG_BASE + a] = case_prog[idx][a];
  endtask

  task automatic hold_halt_button();
    int writes_before;
    int syncs_seen;
    @(posedge raw_clk);
    #1;
    button_halt = 1'b0;
    // Instruction in flight may still finish
    repeat (HOLD_SETTLE) @(posedge raw_clk);
    writes_before = log_addr.size();
    syncs_seen = 0;
    repeat (HOLD_CYCLES - HOLD_SETTLE)
    begin
      @(negedge raw_clk);
      if (sync)
        syncs_seen++;
    end
    @(posedge raw_clk);
    if (syncs_seen != 0 || log_addr.size() != writes_before)
    begin
      $display("Core kept running while button_halt was low: %0d fetches, %0d writes",
               syncs_seen, log_addr.size() - writes_before);
      test_errors++;
    end
    #1;
    button_halt = 1'b1;
  endtask

  task automatic run_case(int idx);
    int   base_writes;
    int   got_writes;
    int   cyc;
    int   syncs;
    int   i;
    logic held;
    logic stopped;
    logic saw_error;
    test_errors = 0;
    held = 1'b0;
    stopped = 1'b0;
    saw_error = 1'b0;
    syncs = 0;
    @(posedge raw_clk);
    #1;
    button_reset = 1'b0;
    button_halt = 1'b1;
    @(posedge raw_clk);
    #1;
    load_memory(idx);
    repeat (2) @(posedge raw_clk);
    #1;
    button_reset = 1'b1;
    base_writes = log_addr.size();

    for (cyc = 0; cyc < MAX_WAIT && !stopped; cyc++)
    begin
      @(negedge raw_clk);
      stopped = halted || error;
      saw_error = error;
      if (sync)
        syncs++;
      if (!stopped && !held && case_hold[idx] > 0 && syncs >= case_hold[idx])
      begin
        hold_halt_button();
        held = 1'b1;
      end
    end

    // Watch for writes after the core stops
    repeat (STOP_WATCH) @(negedge raw_clk);
    if (stopped && !(halted || error))
    begin
      $display("Core left its stopped state during %s", case_name[idx]);
      test_errors++;
    end
    @(posedge raw_clk);
    got_writes = log_addr.size() - base_writes;

    if (!stopped)
    begin
      $display("Timeout: %s did not stop within %0d cycles", case_name[idx], MAX_WAIT);
      test_errors++;
    end
    else if (saw_error && !case_illegal[idx])
    begin
      $display("Core raised error during %s on a legal program", case_name[idx]);
      test_errors++;
    end
    else if (!saw_error && case_illegal[idx])
    begin
      $display("Core did not raise error on the illegal opcode in %s", case_name[idx]);
      test_errors++;
    end

    if (case_hold[idx] > 0 && !held)
    begin
      $display("Halt button was never pressed in %s, too few opcode fetches seen",
               case_name[idx]);
      test_errors++;
    end

    if (got_writes != case_writes[idx])
    begin
      $display("** Error: write count got 0x%0h expected 0x%0h", got_writes, case_writes[idx]);
      test_errors++;
    end
    for (i = 0; i < got_writes && i < case_writes[idx]; i++)
    begin
      check_addr("mem_req.addr", log_addr[base_writes + i], exp_addr[idx][i]);
      check_byte("mem_req.wdata", log_data[base_writes + i], exp_data[idx][i]);
    end

    if (test_errors == 0)
    begin
      pass_count++;
      $display("test %0d %s: ok", idx, case_name[idx]);
    end
    else
    begin
      fail_count++;
      $display("test %0d %s: %0d errors", idx, case_name[idx], test_errors);
    end
  endtask

  initial
  begin
    int idx;
    void'($urandom(61292));
    build_cases();
    for (idx = 0; idx < num_cases; idx++)
      run_case(idx);
    $display("tests run %0d, passed %0d, failed %0d", num_cases, pass_count, fail_count);
    if (fail_count == 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

/* flist.f */
+incdir+testbench
hw/m6502_pkg.sv
hw/cpu_decode.sv
hw/cpu_alu.sv
hw/cpu_regs.sv
hw/cpu_control.sv
hw/m6502_top.sv
testbench/tb_m6502.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module tb_m6502 -o tb_m6502_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/tb_m6502_sim)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -qF '*** TEST PASSED ***'; then
  exit 0
fi
echo "Simulation did not pass"
exit 1
